//--- common/aes_macros.svh
`ifndef AES_MACROS_SVH
`define AES_MACROS_SVH

// one block and one cipher key are both this wide
`define AES_BLOCK_BITS 128

`define AES_NUM_BYTES 16
`define AES_NUM_COLS 4

// last round number, also the width of the round counter compare
`define AES_NUM_ROUNDS 4'd10

`endif

//--- common/aes_data_pkg.sv
`include "aes_macros.svh"

package aes_data_pkg;

    // one column of the state or one word of the key schedule
    typedef logic [`AES_BLOCK_BITS/`AES_NUM_COLS-1:0] aes_word_t;

    // the state is read as bytes by sub and shift, as columns by add and mix
    typedef union packed {
        logic [0:`AES_NUM_BYTES-1][7:0] bytes; // byte 0 is the first input byte
        aes_word_t [0:`AES_NUM_COLS-1] cols;   // column 0 holds bytes 0 to 3
    } aes_block_u;

    // round key as four words, word 0 most significant
    typedef aes_word_t [0:`AES_NUM_COLS-1] aes_key_t;

endpackage

//--- common/aes_ctrl_pkg.sv
package aes_ctrl_pkg;

    // code 3'b110 is unused and falls back to idle in the sequencer
    typedef enum logic [2:0] {
        step_idle = 3'b000,
        step_add  = 3'b001,
        step_sub  = 3'b010,
        step_exp  = 3'b011,
        step_shi  = 3'b100,
        step_mix  = 3'b101,
        step_fin  = 3'b111
    } aes_step_e;

    typedef struct packed {
        aes_step_e  step;  // step carried out at the next edge
        logic       load;  // take plaintext and key at the next edge
        logic [3:0] round;
    } aes_ctrl_t;

endpackage

//--- aes_datapath/aes_sbox.sv
module aes_sbox (
    input  logic [7:0] in_byte,
    output logic [7:0] out_byte
);

    // one table row per high nibble, the low nibble picks the byte in the row
    logic [0:15][7:0] row;

    always_comb begin
        case (in_byte[7:4])
            4'h0: row = 128'h637c777bf26b6fc53001672bfed7ab76;
            4'h1: row = 128'hca82c97dfa5947f0add4a2af9ca472c0;
            4'h2: row = 128'hb7fd9326363ff7cc34a5e5f171d83115;
            4'h3: row = 128'h04c723c31896059a071280e2eb27b275;
            4'h4: row = 128'h09832c1a1b6e5aa0523bd6b329e32f84;
            4'h5: row = 128'h53d100ed20fcb15b6acbbe394a4c58cf;
            4'h6: row = 128'hd0efaafb434d338545f9027f503c9fa8;
            4'h7: row = 128'h51a3408f929d38f5bcb6da2110fff3d2;
            4'h8: row = 128'hcd0c13ec5f974417c4a77e3d645d1973;
            4'h9: row = 128'h60814fdc222a908846eeb814de5e0bdb;
            4'ha: row = 128'he0323a0a4906245cc2d3ac629195e479;
            4'hb: row = 128'he7c8376d8dd54ea96c56f4ea657aae08;
            4'hc: row = 128'hba78252e1ca6b4c6e8dd741f4bbd8b8a;
            4'hd: row = 128'h703eb5664803f60e613557b986c11d9e;
            4'he: row = 128'he1f8981169d98e949b1e87e9ce5528df;
            4'hf: row = 128'h8ca1890dbfe6426841992d0fb054bb16;
            default: row = '0;
        endcase
    end

    assign out_byte = row[in_byte[3:0]];

endmodule

//--- aes_datapath/aes_key_step.sv
`include "aes_macros.svh"

module aes_key_step (
    input  aes_data_pkg::aes_key_t key,
    input  logic [3:0]             round,
    output aes_data_pkg::aes_key_t next_key
);

    import aes_data_pkg::*;

    aes_word_t  rot_word;
    aes_word_t  sub_word;
    logic [7:0] sub_bytes [4];
    logic [7:0] rcon;

    assign rot_word = {key[`AES_NUM_COLS-1][23:0], key[`AES_NUM_COLS-1][31:24]};

    for (genvar i = 0; i < 4; i++) begin : g_sbox
        aes_sbox sbox_i (
            .in_byte (rot_word[31-8*i -: 8]),
            .out_byte(sub_bytes[i])
        );
    end

    assign sub_word = {sub_bytes[0], sub_bytes[1], sub_bytes[2], sub_bytes[3]};

    // the counter already names the round whose key is being built
    always_comb begin
        case (round)
            4'd1:    rcon = 8'h01;
            4'd2:    rcon = 8'h02;
            4'd3:    rcon = 8'h04;
            4'd4:    rcon = 8'h08;
            4'd5:    rcon = 8'h10;
            4'd6:    rcon = 8'h20;
            4'd7:    rcon = 8'h40;
            4'd8:    rcon = 8'h80;
            4'd9:    rcon = 8'h1b;
            4'd10:   rcon = 8'h36;
            default: rcon = 8'h00;
        endcase
    end

    always_comb begin
        next_key[0] = key[0] ^ sub_word ^ {rcon, 24'h000000};
        for (int i = 1; i < `AES_NUM_COLS; i++) begin
            next_key[i] = key[i] ^ next_key[i-1]; // each word chains on the new one before it
        end
    end

endmodule

//--- aes_datapath/aes_datapath.sv
`include "aes_macros.svh"

module aes_datapath (
    input  logic                     clk,
    input  logic                     res,
    input  aes_ctrl_pkg::aes_ctrl_t  ctrl,
    input  aes_data_pkg::aes_block_u plaintext,
    input  aes_data_pkg::aes_key_t   key,
    output aes_data_pkg::aes_block_u state
);

    import aes_data_pkg::*;
    import aes_ctrl_pkg::*;

    localparam int NUM_ROWS = `AES_NUM_BYTES / `AES_NUM_COLS;

    aes_block_u state_q;
    aes_key_t   key_q;
    aes_key_t   next_key;
    aes_block_u add_out;
    aes_block_u sub_out;
    aes_block_u shi_out;
    aes_block_u mix_out;
    logic [7:0] sbox_out [`AES_NUM_BYTES];

    function automatic logic [7:0] xtime(input logic [7:0] b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    // one column times the fixed matrix 02 03 01 01 in GF(2^8)
    function automatic aes_word_t mix_col(input aes_word_t w);
        logic [7:0] a0;
        logic [7:0] a1;
        logic [7:0] a2;
        logic [7:0] a3;
        a0 = w[31:24];
        a1 = w[23:16];
        a2 = w[15:8];
        a3 = w[7:0];
        return {xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3,
                a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3,
                a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3,
                xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3)};
    endfunction

    for (genvar i = 0; i < `AES_NUM_BYTES; i++) begin : g_sbox
        aes_sbox sbox_i (
            .in_byte (state_q.bytes[i]),
            .out_byte(sbox_out[i])
        );
    end

    aes_key_step key_step_i (
        .key     (key_q),
        .round   (ctrl.round),
        .next_key(next_key)
    );

    always_comb begin
        for (int c = 0; c < `AES_NUM_COLS; c++) begin
            add_out.cols[c] = state_q.cols[c] ^ key_q[c];
            mix_out.cols[c] = mix_col(state_q.cols[c]);
        end
    end

    always_comb begin
        for (int i = 0; i < `AES_NUM_BYTES; i++) begin
            sub_out.bytes[i] = sbox_out[i];
        end
    end

    // byte r + 4c sits in row r, column c, and row r turns left by r
    always_comb begin
        for (int c = 0; c < `AES_NUM_COLS; c++) begin
            for (int r = 0; r < NUM_ROWS; r++) begin
                shi_out.bytes[NUM_ROWS*c + r] =
                    state_q.bytes[NUM_ROWS*((c + r) % `AES_NUM_COLS) + r];
            end
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state_q <= '0;
            key_q   <= '0;
        end else if (ctrl.load) begin
            state_q <= plaintext;
            key_q   <= key;
        end else begin
            case (ctrl.step)
                step_add: state_q <= add_out;
                step_sub: state_q <= sub_out;
                step_exp: key_q   <= next_key; // only step that touches the key
                step_shi: state_q <= shi_out;
                step_mix: state_q <= mix_out;
                default:  ;
            endcase
        end
    end

    assign state = state_q;

endmodule

//--- rtl/aes_step_fsm.sv
`include "aes_macros.svh"

module aes_step_fsm (
    input  logic                    clk,
    input  logic                    res,
    input  logic                    start,
    output aes_ctrl_pkg::aes_ctrl_t ctrl,
    output logic                    busy,
    output logic                    done
);

    import aes_ctrl_pkg::*;

    aes_step_e  step_q;
    aes_step_e  step_d;
    logic [3:0] round_q;
    logic [3:0] round_d;
    logic       accept;

    assign busy   = (step_q != step_idle) && (step_q != step_fin);
    assign done   = (step_q == step_fin);
    assign accept = start && !busy; // a start during a run is dropped

    always_comb begin
        step_d  = step_q;
        round_d = round_q;
        case (step_q)
            step_idle, step_fin: begin
                if (accept) begin
                    step_d  = step_add;
                    round_d = 4'd0;
                end else begin
                    step_d = step_idle;
                end
            end
            step_add: begin
                if (round_q == `AES_NUM_ROUNDS) begin
                    step_d = step_fin;
                end else begin
                    step_d  = step_sub;
                    round_d = round_q + 4'd1;
                end
            end
            step_sub: step_d = step_exp;
            step_exp: step_d = step_shi;
            step_shi: step_d = (round_q == `AES_NUM_ROUNDS) ? step_add : step_mix; // last round skips mix
            step_mix: step_d = step_add;
            default:  step_d = step_idle;
        endcase
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            step_q  <= step_idle;
            round_q <= 4'd0;
        end else begin
            step_q  <= step_d;
            round_q <= round_d;
        end
    end

    assign ctrl = '{step: step_q, load: accept, round: round_q};

endmodule

//--- rtl/aes_core.sv
module aes_core (
    input  logic                     clk,
    input  logic                     res,
    input  logic                     start,
    input  aes_data_pkg::aes_block_u plaintext,
    input  aes_data_pkg::aes_key_t   key,
    output logic                     busy,
    output logic                     done,
    output aes_data_pkg::aes_block_u ciphertext
);

    import aes_ctrl_pkg::*;

    aes_ctrl_t ctrl;

    // sequencer decides the order, the datapath only executes
    aes_step_fsm step_fsm_i (
        .clk  (clk),
        .res  (res),
        .start(start),
        .ctrl (ctrl),
        .busy (busy),
        .done (done)
    );

    aes_datapath datapath_i (
        .clk      (clk),
        .res      (res),
        .ctrl     (ctrl),
        .plaintext(plaintext),
        .key      (key),
        .state    (ciphertext) // result stays in the state register
    );

endmodule

//--- tests/aes_core_sva.sv
module aes_core_sva (
    input logic clk,
    input logic res,
    input logic start,
    input logic busy,
    input logic done
);

    // a start counts only when the core is not running a block
    logic accept;

    assign accept = start && !busy;

    done_one_cycle: assert property (
        @(posedge clk) disable iff (!res)
        done |=> !done
    ) else $error("done stayed high for two cycles in a row");

    // done only ends a busy run and never overlaps it
    done_ends_busy: assert property (
        @(posedge clk) disable iff (!res)
        done |-> !busy && $past(busy)
    ) else $error("done came without a busy cycle before it or together with busy");

    // done rises at the 50th edge after the accepting edge, seen one sample later
    done_latency: assert property (
        @(posedge clk) disable iff (!res)
        accept |=> (!done) [*50] ##1 done
    ) else $error("done did not follow an accepted start after exactly 50 edges");

endmodule

bind aes_core aes_core_sva aes_core_sva_i (
    .clk  (clk),
    .res  (res),
    .start(start),
    .busy (busy),
    .done (done)
);

//--- tests/aes_core_tb.sv
`include "aes_macros.svh"

module aes_core_tb;

    import aes_data_pkg::*;

    localparam int NUM_VECS    = 3;
    localparam int NUM_STEPS   = 5 * `AES_NUM_ROUNDS; // 1 + 9*5 + 4 steps after the load
    localparam int WAIT_LIMIT  = 60;
    localparam int HOLD_CYCLES = 5;
    localparam int WATCHDOG    = (NUM_VECS + 2) * 60 * 100;

    typedef struct packed {
        aes_block_u plaintext;
        aes_key_t   key;
        aes_block_u expected;
        logic       mid_start; // pulse start again while this block runs
    } test_vec_t;

    logic       clk;
    logic       res;
    logic       start;
    aes_block_u plaintext;
    aes_key_t   key;
    logic       busy;
    logic       done;
    aes_block_u ciphertext;

    test_vec_t vecs [NUM_VECS];
    int        error_count;
    int        test_count;
    int        fail_count;

    aes_core aes_core_i (
        .clk       (clk),
        .res       (res),
        .start     (start),
        .plaintext (plaintext),
        .key       (key),
        .busy      (busy),
        .done      (done),
        .ciphertext(ciphertext)
    );

    always #50 clk = ~clk;

    function automatic test_vec_t make_vec(input logic [`AES_BLOCK_BITS-1:0] pt,
                                           input logic [`AES_BLOCK_BITS-1:0] k,
                                           input logic [`AES_BLOCK_BITS-1:0] ct,
                                           input logic                       mid);
        test_vec_t v;
        v.plaintext = pt;
        v.key       = k;
        v.expected  = ct;
        v.mid_start = mid;
        return v;
    endfunction

    task automatic check_block(input string name, input aes_block_u got, input aes_block_u exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s: got %b, expected %b", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("[ERROR] %0t %s: got %0d, expected %0d", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        test_count++;
        if (error_count == errors_before) begin
            $display("test %0d %s: pass", test_count, name);
        end else begin
            fail_count++;
            $display("test %0d %s: FAIL", test_count, name);
        end
    endtask

    task automatic check_reset();
        int errors_before;
        errors_before = error_count;
        check_flag("busy", busy, 1'b0);
        check_flag("done", done, 1'b0);
        check_block("ciphertext", ciphertext, '0);
        finish_test("reset", errors_before);
    endtask

    // called 10 units after an edge, the next edge is the accepting one
    task automatic run_block(input int idx);
        test_vec_t v;
        int        cycles;
        int        errors_before;
        v             = vecs[idx];
        errors_before = error_count;
        start         = 1'b1;
        plaintext     = v.plaintext;
        key           = v.key;
        @(posedge clk);
        #10;
        start = 1'b0;
        check_flag("busy", busy, 1'b1);
        check_flag("done", done, 1'b0);
        cycles = 0;
        while (!done && cycles < WAIT_LIMIT) begin
            if (v.mid_start && cycles == 10) begin
                start     = 1'b1; // must be dropped, the core is busy
                plaintext = ~v.plaintext;
                key       = ~v.key;
            end else begin
                start = 1'b0;
            end
            @(posedge clk);
            #10;
            cycles++;
            if (!done) begin
                check_flag("busy", busy, 1'b1);
            end
        end
        if (!done) begin
            $display("%0t: done did not arrive within %0d cycles of the start",
                     $time, WAIT_LIMIT);
            error_count++;
        end else begin
            check_count("done latency", cycles, NUM_STEPS);
            check_flag("busy", busy, 1'b0);
            check_block("ciphertext", ciphertext, v.expected);
        end
        finish_test($sformatf("vector %0d", idx), errors_before);
    endtask

    task automatic check_hold();
        aes_block_u held;
        int         errors_before;
        errors_before = error_count;
        held          = ciphertext;
        repeat (HOLD_CYCLES) begin
            @(posedge clk);
            #10;
            check_block("ciphertext", ciphertext, held);
            check_flag("done", done, 1'b0);
            check_flag("busy", busy, 1'b0);
        end
        finish_test("result hold", errors_before);
    endtask

    initial begin
        clk         = 1'b0;
        res         = 1'b0;
        start       = 1'b0;
        plaintext   = '0;
        key         = '0;
        error_count = 0;
        test_count  = 0;
        fail_count  = 0;

        vecs[0] = make_vec(128'h3243f6a8885a308d313198a2e0370734,
                           128'h2b7e151628aed2a6abf7158809cf4f3c,
                           128'h3925841d02dc09fbdc118597196a0b32, 1'b1);
        vecs[1] = make_vec(128'h00112233445566778899aabbccddeeff,
                           128'h000102030405060708090a0b0c0d0e0f,
                           128'h69c4e0d86a7b0430d8cdb78070b4c55a, 1'b0);
        vecs[2] = make_vec(128'h00000000000000000000000000000000,
                           128'h00000000000000000000000000000000,
                           128'h66e94bd4ef8a2c3b884cfa59ca342b2e, 1'b0);

        repeat (2) @(posedge clk);
        #10;
        res = 1'b1;
        check_reset();

        // each block starts in the done cycle of the one before
        for (int i = 0; i < NUM_VECS; i++) begin
            run_block(i);
        end
        check_hold();

        $display("%0d tests run, %0d failed, %0d check errors",
                 test_count, fail_count, error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG);
        $display("timeout: the run did not finish within %0d time units", WATCHDOG);
        $display("Done: errors found");
        $finish;
    end

endmodule

//--- flist.f
+incdir+common
common/aes_data_pkg.sv
common/aes_ctrl_pkg.sv
aes_datapath/aes_sbox.sv
aes_datapath/aes_key_step.sv
aes_datapath/aes_datapath.sv
rtl/aes_step_fsm.sv
rtl/aes_core.sv
tests/aes_core_sva.sv
tests/aes_core_tb.sv

//--- Bender.yml
package:
  name: aes_core

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/aes_data_pkg.sv
      - common/aes_ctrl_pkg.sv
      - aes_datapath/aes_sbox.sv
      - aes_datapath/aes_key_step.sv
      - aes_datapath/aes_datapath.sv
      - rtl/aes_step_fsm.sv
      - rtl/aes_core.sv
  - target: test
    include_dirs:
      - common
    files:
      - tests/aes_core_sva.sv
      - tests/aes_core_tb.sv
